// File: clock_reconfig_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module clock_reconfig_sequencer (
    input  wire                                  clk,
    input  wire                                  reset_state_machine,
    input  wire                                  reconfig_start,
    input  wire hbm_ctrl_pkg::clk_profile_e      reconfig_profile,
    input  wire                                  drp_done,
    input  wire                                  clk_locked,
    output logic                                 drp_req,
    output logic [hbm_ctrl_pkg::DRP_ADDR_W-1:0]  drp_addr,
    output logic [hbm_ctrl_pkg::DRP_DATA_W-1:0]  drp_data,
    output logic                                 reconfig_busy
);

    typedef enum logic [1:0] {IDLE, WRITE, GAP, LOCK_WAIT} state_e;

    localparam logic [3:0] LAST_WRITE = 4'(hbm_ctrl_pkg::DRP_WRITES - 1);

    state_e                     state;
    logic [3:0]                 write_index;
    hbm_ctrl_pkg::clk_profile_e profile;

    assign drp_req       = (state == WRITE);
    assign reconfig_busy = (state != IDLE);

    // Table lookup for the current write
    assign drp_addr = hbm_ctrl_pkg::DRP_ADDR_TABLE[write_index];
    assign drp_data = hbm_ctrl_pkg::PROFILE_DATA[profile][write_index];

    //////////////////////////////////////////////////
    // Write sequence
    always_ff @(posedge clk)
    begin
        if (reset_state_machine)
        begin
            state       <= IDLE;
            write_index <= 4'd0;
            profile     <= hbm_ctrl_pkg::CLK_650;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (reconfig_start)
                    begin
                        state       <= WRITE;
                        write_index <= 4'd0;
                        profile     <= reconfig_profile;
                    end
                end
                WRITE:
                begin
                    if (drp_done)
                    begin
                        if (write_index == LAST_WRITE)
                            state <= LOCK_WAIT;  // Reconfig write done
                        else
                        begin
                            write_index <= write_index + 4'd1;
                            state       <= GAP;
                        end
                    end
                end
                GAP:
                    state <= WRITE;  // One idle cycle between writes
                LOCK_WAIT:
                begin
                    if (clk_locked)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Request held steady until the DRP answers
    assert property (@(posedge clk) disable iff (reset_state_machine)
        drp_req && !drp_done |=> drp_req && $stable(drp_addr) && $stable(drp_data));

endmodule

`default_nettype wire

// File: command_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module command_decoder (
    input  wire                                  clk,
    input  wire                                  reset_state_machine,
    input  wire                                  rx_valid,
    input  wire hbm_ctrl_pkg::byte_t             rx_data,
    input  wire [6:0]                            hbm_temperature,
    input  wire                                  mask_busy,
    input  wire                                  mask_loaded,
    input  wire                                  reconfig_busy,
    output logic                                 tx_valid,
    output hbm_ctrl_pkg::byte_t                  tx_data,
    output logic                                 start,
    output hbm_ctrl_pkg::rw_mode_e               read_write,
    output logic                                 address_inc,
    output logic [hbm_ctrl_pkg::LENGTH_W-1:0]    length,
    output logic                                 mask_begin,
    output logic                                 reconfig_start,
    output hbm_ctrl_pkg::clk_profile_e           reconfig_profile,
    output logic                                 soft_reset
);

    typedef enum logic {IDLE, LENGTH_WAIT} state_e;

    state_e                state;
    hbm_ctrl_pkg::opcode_e opcode;
    logic                  byte_taken;
    logic                  cmd_valid;
    logic                  length_taken;
    logic                  clear_regs;
    logic                  resp_valid;
    hbm_ctrl_pkg::byte_t   resp_data;

    assign opcode       = hbm_ctrl_pkg::opcode_e'(rx_data);
    assign byte_taken   = rx_valid && !mask_busy && !reconfig_busy;  // Dropped while busy
    assign cmd_valid    = byte_taken && (state == IDLE);
    assign length_taken = byte_taken && (state == LENGTH_WAIT);

    assign mask_begin = cmd_valid && (opcode == hbm_ctrl_pkg::OP_PORT_MASK);
    assign soft_reset = cmd_valid && (opcode == hbm_ctrl_pkg::OP_RESET);
    assign reconfig_start = cmd_valid && (opcode inside {hbm_ctrl_pkg::OP_CLK_650,
                                                         hbm_ctrl_pkg::OP_CLK_450,
                                                         hbm_ctrl_pkg::OP_CLK_325});
    assign clear_regs = reset_state_machine || soft_reset;

    always_comb
    begin
        case (opcode)
            hbm_ctrl_pkg::OP_CLK_450: reconfig_profile = hbm_ctrl_pkg::CLK_450;
            hbm_ctrl_pkg::OP_CLK_325: reconfig_profile = hbm_ctrl_pkg::CLK_325;
            default:                  reconfig_profile = hbm_ctrl_pkg::CLK_650;
        endcase
    end

    //////////////////////////////////////////////////
    // Response byte select for all sources
    always_comb
    begin
        resp_valid = 1'b1;
        resp_data  = 8'h00;
        if (mask_loaded)
            resp_data = hbm_ctrl_pkg::RESP_MASK;
        else if (length_taken)
            resp_data = hbm_ctrl_pkg::RESP_LENGTH;
        else if (cmd_valid)
        begin
            case (opcode)
                hbm_ctrl_pkg::OP_START:       resp_data = hbm_ctrl_pkg::RESP_START;
                hbm_ctrl_pkg::OP_STOP:        resp_data = hbm_ctrl_pkg::RESP_STOP;
                hbm_ctrl_pkg::OP_WRITE:       resp_data = hbm_ctrl_pkg::RESP_WRITE;
                hbm_ctrl_pkg::OP_READ:        resp_data = hbm_ctrl_pkg::RESP_READ;
                hbm_ctrl_pkg::OP_QREAD:       resp_data = hbm_ctrl_pkg::RESP_QREAD;
                hbm_ctrl_pkg::OP_QWRITE:      resp_data = hbm_ctrl_pkg::RESP_QWRITE;
                hbm_ctrl_pkg::OP_ADDR_INC:    resp_data = hbm_ctrl_pkg::RESP_ADDR_INC;
                hbm_ctrl_pkg::OP_ADDR_STATIC: resp_data = hbm_ctrl_pkg::RESP_ADDR_STATIC;
                hbm_ctrl_pkg::OP_RESET:       resp_data = hbm_ctrl_pkg::RESP_RESET;
                hbm_ctrl_pkg::OP_CLK_650:     resp_data = hbm_ctrl_pkg::RESP_CLK_650;
                hbm_ctrl_pkg::OP_CLK_450:     resp_data = hbm_ctrl_pkg::RESP_CLK_450;
                hbm_ctrl_pkg::OP_CLK_325:     resp_data = hbm_ctrl_pkg::RESP_CLK_325;
                hbm_ctrl_pkg::OP_HBM_TEMP:    resp_data = {1'b0, hbm_temperature};
                default:                      resp_valid = 1'b0;  // Mask, length, unknown
            endcase
        end
        else
            resp_valid = 1'b0;
    end

    //////////////////////////////////////////////////
    // Mode and length registers
    always_ff @(posedge clk)
    begin
        if (clear_regs)
        begin
            state       <= IDLE;
            start       <= 1'b0;
            read_write  <= hbm_ctrl_pkg::RW_READ;
            address_inc <= 1'b0;
            length      <= hbm_ctrl_pkg::LENGTH_RESET;
        end
        else if (length_taken)
        begin
            length <= rx_data[hbm_ctrl_pkg::LENGTH_W-1:0];
            state  <= IDLE;
        end
        else if (cmd_valid)
        begin
            case (opcode)
                hbm_ctrl_pkg::OP_START:       start       <= 1'b1;
                hbm_ctrl_pkg::OP_STOP:        start       <= 1'b0;
                hbm_ctrl_pkg::OP_WRITE:       read_write  <= hbm_ctrl_pkg::RW_WRITE;
                hbm_ctrl_pkg::OP_READ:        read_write  <= hbm_ctrl_pkg::RW_READ;
                hbm_ctrl_pkg::OP_QREAD:       read_write  <= hbm_ctrl_pkg::RW_QREAD;
                hbm_ctrl_pkg::OP_QWRITE:      read_write  <= hbm_ctrl_pkg::RW_QWRITE;
                hbm_ctrl_pkg::OP_ADDR_INC:    address_inc <= 1'b1;
                hbm_ctrl_pkg::OP_ADDR_STATIC: address_inc <= 1'b0;
                hbm_ctrl_pkg::OP_LENGTH:      state       <= LENGTH_WAIT;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_state_machine)
            tx_valid <= 1'b0;
        else
            tx_valid <= resp_valid;
    end

    always_ff @(posedge clk)
    begin
        tx_data <= resp_data;
    end

    // UART pacing keeps responses apart
    assert property (@(posedge clk) disable iff (reset_state_machine)
        tx_valid |=> !tx_valid);

    // Sequencer must be idle and accept the start
    assert property (@(posedge clk) disable iff (reset_state_machine)
        reconfig_start |-> !reconfig_busy ##1 reconfig_busy);

endmodule

`default_nettype wire

// File: hbm_ctrl_pkg.sv
`default_nettype none

package hbm_ctrl_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [7:0] {
        OP_HBM_TEMP    = 8'h2F,
        OP_START       = 8'h30,
        OP_STOP        = 8'h31,
        OP_WRITE       = 8'h32,
        OP_READ        = 8'h33,
        OP_QREAD       = 8'h35,
        OP_QWRITE      = 8'h36,
        OP_ADDR_INC    = 8'h37,
        OP_ADDR_STATIC = 8'h38,
        OP_PORT_MASK   = 8'h39,
        OP_LENGTH      = 8'h3A,
        OP_CLK_650     = 8'h3C,
        OP_CLK_450     = 8'h3D,
        OP_CLK_325     = 8'h3E,
        OP_RESET       = 8'h40
    } opcode_e;

    typedef enum logic [7:0] {
        RESP_START       = 8'h41,
        RESP_STOP        = 8'h42,
        RESP_WRITE       = 8'h43,
        RESP_READ        = 8'h44,
        RESP_QREAD       = 8'h46,
        RESP_QWRITE      = 8'h47,
        RESP_ADDR_INC    = 8'h48,
        RESP_ADDR_STATIC = 8'h49,
        RESP_MASK        = 8'h4A,
        RESP_RESET       = 8'h4B,
        RESP_LENGTH      = 8'h4C,
        RESP_CLK_650     = 8'h4E,
        RESP_CLK_450     = 8'h4F,
        RESP_CLK_325     = 8'h50
    } resp_e;

    // Code 2 (read-write mix) not supported
    typedef enum logic [2:0] {
        RW_READ   = 3'd0,
        RW_WRITE  = 3'd1,
        RW_QREAD  = 3'd3,
        RW_QWRITE = 3'd4
    } rw_mode_e;

    typedef enum logic [1:0] {CLK_650, CLK_450, CLK_325} clk_profile_e;

    localparam int PORT_COUNT = 32;
    localparam int LENGTH_W = 4;
    localparam logic [LENGTH_W-1:0] LENGTH_RESET = 4'd15;

    localparam int DRP_ADDR_W = 11;
    localparam int DRP_DATA_W = 32;
    localparam int DRP_WRITES = 13;

    //////////////////////////////////////////////////
    // Last write of the MMCM register map kicks off reconfig
    localparam logic [DRP_ADDR_W-1:0] DRP_ADDR_TABLE [DRP_WRITES] = '{
        11'h304, 11'h308, 11'h30C, 11'h310, 11'h33C, 11'h340, 11'h344,
        11'h348, 11'h34C, 11'h350, 11'h354, 11'h358, 11'h35C
    };

    localparam logic [DRP_DATA_W-1:0] PROFILE_DATA [3][DRP_WRITES] = '{
        '{32'h1041, 32'h0000, 32'h1105, 32'h0080, 32'h1041, 32'h1146, 32'h0080,
          32'h0384, 32'h7C01, 32'h7FE9, 32'h0900, 32'h1890, 32'h0003},  // 650 MHz
        '{32'h1041, 32'h0000, 32'h1105, 32'h0080, 32'h1041, 32'h1105, 32'h0080,
          32'h03E8, 32'h6401, 32'h67E9, 32'h0900, 32'h1890, 32'h0003},  // 450 MHz
        '{32'h1082, 32'h0000, 32'h1249, 32'h0000, 32'h1041, 32'h1187, 32'h0080,
          32'h02EE, 32'h7C01, 32'h7FE9, 32'h0900, 32'h8890, 32'h0003}   // 325 MHz
    };

endpackage

`default_nettype wire

// File: hbm_test_ctrl.f
hbm_ctrl_pkg.sv
command_decoder.sv
port_mask_loader.sv
clock_reconfig_sequencer.sv
hbm_test_ctrl.sv
tb_hbm_test_ctrl.sv

// File: hbm_test_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module hbm_test_ctrl (
    input  wire                                  clk,
    input  wire                                  reset_state_machine,
    input  wire                                  rx_valid,
    input  wire hbm_ctrl_pkg::byte_t             rx_data,
    input  wire [6:0]                            hbm_temperature,
    input  wire                                  drp_done,
    input  wire                                  clk_locked,
    output logic                                 tx_valid,
    output hbm_ctrl_pkg::byte_t                  tx_data,
    output logic                                 start,
    output hbm_ctrl_pkg::rw_mode_e               read_write,
    output logic                                 address_inc,
    output logic [hbm_ctrl_pkg::PORT_COUNT-1:0]  port_mask,
    output logic [hbm_ctrl_pkg::LENGTH_W-1:0]    length,
    output logic                                 drp_req,
    output logic [hbm_ctrl_pkg::DRP_ADDR_W-1:0]  drp_addr,
    output logic [hbm_ctrl_pkg::DRP_DATA_W-1:0]  drp_data
);

    logic                       mask_begin;
    logic                       mask_busy;
    logic                       mask_loaded;
    logic                       mask_reset;
    logic                       soft_reset;
    logic                       reconfig_start;
    logic                       reconfig_busy;
    hbm_ctrl_pkg::clk_profile_e reconfig_profile;

    assign mask_reset = reset_state_machine | soft_reset;  // Reset command clears the mask

    command_decoder u_command_decoder (
        .clk                 (clk),
        .reset_state_machine (reset_state_machine),
        .rx_valid            (rx_valid),
        .rx_data             (rx_data),
        .hbm_temperature     (hbm_temperature),
        .mask_busy           (mask_busy),
        .mask_loaded         (mask_loaded),
        .reconfig_busy       (reconfig_busy),
        .tx_valid            (tx_valid),
        .tx_data             (tx_data),
        .start               (start),
        .read_write          (read_write),
        .address_inc         (address_inc),
        .length              (length),
        .mask_begin          (mask_begin),
        .reconfig_start      (reconfig_start),
        .reconfig_profile    (reconfig_profile),
        .soft_reset          (soft_reset)
    );

    port_mask_loader u_port_mask_loader (
        .clk                 (clk),
        .reset_state_machine (mask_reset),
        .rx_valid            (rx_valid),
        .rx_data             (rx_data),
        .mask_begin          (mask_begin),
        .mask_busy           (mask_busy),
        .mask_loaded         (mask_loaded),
        .port_mask           (port_mask)
    );

    clock_reconfig_sequencer u_clock_reconfig_sequencer (
        .clk                 (clk),
        .reset_state_machine (reset_state_machine),
        .reconfig_start      (reconfig_start),
        .reconfig_profile    (reconfig_profile),
        .drp_done            (drp_done),
        .clk_locked          (clk_locked),
        .drp_req             (drp_req),
        .drp_addr            (drp_addr),
        .drp_data            (drp_data),
        .reconfig_busy       (reconfig_busy)
    );

endmodule

`default_nettype wire

// File: hbm_test_ctrl_vectors.txt
# name kind count byte0 byte1 byte2 byte3 response value (hex, response 100 means none expected)
# kind picks the output compared with value; temp drives value as temperature, clk uses it as profile
after_reset     idle    0 00 00 00 00 100 0
op_start        start   1 30 00 00 00 41  1
op_write        rw      1 32 00 00 00 43  1
op_addr_inc     ainc    1 37 00 00 00 48  1
op_qread        rw      1 35 00 00 00 46  3
op_qwrite       rw      1 36 00 00 00 47  4
op_read         rw      1 33 00 00 00 44  0
op_addr_static  ainc    1 38 00 00 00 49  0
op_stop         start   1 31 00 00 00 42  0
mask_load       mask    4 A5 3C 0F 81 4A  A53C0F81
mask_mode_byte  mask    4 12 30 34 56 4A  12303456
length_set      length  2 3A 27 00 00 4C  7
length_high     length  2 3A F2 00 00 4C  2
op_start_again  start   1 30 00 00 00 41  1
op_qwrite_again rw      1 36 00 00 00 47  4
op_inc_again    ainc    1 37 00 00 00 48  1
soft_reset      idle    1 40 00 00 00 4B  0
temp_read       temp    1 2F 00 00 00 25  25
temp_max        temp    1 2F 00 00 00 7F  7F
undef_3b        none    1 3B 00 00 00 100 0
undef_34        none    1 34 00 00 00 100 0
undef_41        none    1 41 00 00 00 100 0
clk_650         clk     2 3C 30 00 00 4E  0
clk_450         clk     2 3D 37 00 00 4F  1
clk_325         clk     3 3E 3A 05 00 50  2
after_clk       idle    0 00 00 00 00 100 0

// File: port_mask_loader.sv
`timescale 1ns/10ps
`default_nettype none

module port_mask_loader (
    input  wire                                  clk,
    input  wire                                  reset_state_machine,
    input  wire                                  rx_valid,
    input  wire hbm_ctrl_pkg::byte_t             rx_data,
    input  wire                                  mask_begin,
    output logic                                 mask_busy,
    output logic                                 mask_loaded,
    output logic [hbm_ctrl_pkg::PORT_COUNT-1:0]  port_mask
);

    logic [1:0]                            byte_count;
    logic [hbm_ctrl_pkg::PORT_COUNT-9:0]   mask_shift;  // First three bytes

    assign mask_loaded = mask_busy && rx_valid && (byte_count == 2'd3);

    always_ff @(posedge clk)
    begin
        if (reset_state_machine)
        begin
            mask_busy  <= 1'b0;
            byte_count <= 2'd0;
            port_mask  <= '0;
        end
        else if (mask_begin)
        begin
            mask_busy  <= 1'b1;
            byte_count <= 2'd0;
        end
        else if (mask_busy && rx_valid)
        begin
            byte_count <= byte_count + 2'd1;
            if (byte_count == 2'd3)
            begin
                mask_busy <= 1'b0;
                port_mask <= {mask_shift, rx_data};  // First byte lands on top
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (mask_busy && rx_valid)
            mask_shift <= {mask_shift[hbm_ctrl_pkg::PORT_COUNT-17:0], rx_data};
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

TOP=tb_hbm_test_ctrl
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f hbm_test_ctrl.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb_hbm_test_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_hbm_test_ctrl;

    localparam int MAX_VECTORS = 64;
    localparam int WRITES = 13;
    localparam logic [31:0] NO_RESP = 32'h100;

    localparam logic [10:0] EXP_ADDR [WRITES] = '{
        11'h304, 11'h308, 11'h30C, 11'h310, 11'h33C, 11'h340, 11'h344,
        11'h348, 11'h34C, 11'h350, 11'h354, 11'h358, 11'h35C
    };

    localparam logic [31:0] EXP_DATA [3][WRITES] = '{
        '{32'h1041, 32'h0000, 32'h1105, 32'h0080, 32'h1041, 32'h1146, 32'h0080,
          32'h0384, 32'h7C01, 32'h7FE9, 32'h0900, 32'h1890, 32'h0003},
        '{32'h1041, 32'h0000, 32'h1105, 32'h0080, 32'h1041, 32'h1105, 32'h0080,
          32'h03E8, 32'h6401, 32'h67E9, 32'h0900, 32'h1890, 32'h0003},
        '{32'h1082, 32'h0000, 32'h1249, 32'h0000, 32'h1041, 32'h1187, 32'h0080,
          32'h02EE, 32'h7C01, 32'h7FE9, 32'h0900, 32'h8890, 32'h0003}
    };

    logic        clk = 1'b0;
    logic        reset_state_machine;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic [6:0]  hbm_temperature;
    logic        drp_done;
    logic        clk_locked;
    wire         tx_valid;
    wire  [7:0]  tx_data;
    wire         start;
    wire  [2:0]  read_write;
    wire         address_inc;
    wire  [31:0] port_mask;
    wire  [3:0]  length;
    wire         drp_req;
    wire  [10:0] drp_addr;
    wire  [31:0] drp_data;

    string       vec_name [MAX_VECTORS];
    string       vec_kind [MAX_VECTORS];
    int          vec_count [MAX_VECTORS];
    logic [7:0]  vec_byte [MAX_VECTORS][4];
    logic [31:0] vec_resp [MAX_VECTORS];
    logic [31:0] vec_value [MAX_VECTORS];
    int          num_vectors = 0;

    int          cycle = 0;
    int          cycle_limit = 0;
    int          errors = 0;
    int          failed_tests = 0;
    int          seed = 41;
    logic [7:0]  resp_data_q [$];
    int          resp_cycle_q [$];
    int          drp_count = 0;
    int          drp_first_cycle = 0;
    logic [10:0] drp_addr_seen [16];
    logic [31:0] drp_data_seen [16];

    hbm_test_ctrl DUT (
        .clk                 (clk),
        .reset_state_machine (reset_state_machine),
        .rx_valid            (rx_valid),
        .rx_data             (rx_data),
        .hbm_temperature     (hbm_temperature),
        .drp_done            (drp_done),
        .clk_locked          (clk_locked),
        .tx_valid            (tx_valid),
        .tx_data             (tx_data),
        .start               (start),
        .read_write          (read_write),
        .address_inc         (address_inc),
        .port_mask           (port_mask),
        .length              (length),
        .drp_req             (drp_req),
        .drp_addr            (drp_addr),
        .drp_data            (drp_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle >= cycle_limit)
        begin
            $display("Timeout: run stopped after %0d cycles", cycle);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    always @(posedge clk)
    begin
        if (tx_valid === 1'b1)
        begin
            resp_data_q.push_back(tx_data);
            resp_cycle_q.push_back(cycle);
        end
    end

    //////////////////////////////////////////////////
    // DRP responder with random latency
    initial
    begin : drp_responder
        int delay;
        drp_done   = 1'b0;
        clk_locked = 1'b1;
        forever
        begin
            @(posedge clk);
            if (drp_req === 1'b1)
            begin
                if (drp_count == 0)
                begin
                    drp_first_cycle = cycle;
                    clk_locked <= 1'b0;  // Lock lost during reconfig
                end
                if (drp_count < 16)
                begin
                    drp_addr_seen[drp_count] = drp_addr;
                    drp_data_seen[drp_count] = drp_data;
                end
                delay = 1 + ($unsigned($random(seed)) % 8);
                repeat (delay - 1) @(posedge clk);
                drp_done <= 1'b1;
                @(posedge clk);
                drp_done <= 1'b0;
                drp_count = drp_count + 1;
                if (drp_count == WRITES)
                begin
                    repeat (5) @(posedge clk);
                    clk_locked <= 1'b1;
                end
            end
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %0s %0s: expected %0h, actual %0h", test, what, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic send_byte(input logic [7:0] value, output int sent_cycle);
        @(posedge clk);
        rx_valid <= 1'b1;
        rx_data  <= value;
        sent_cycle = cycle;
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    task automatic check_drp_writes(input string test, input int profile);
        check_value(test, "DRP write count", WRITES, drp_count);
        for (int i = 0; i < WRITES && i < drp_count; i++)
        begin
            check_value(test, $sformatf("DRP address %0d", i), 32'(EXP_ADDR[i]),
                        32'(drp_addr_seen[i]));
            check_value(test, $sformatf("DRP data %0d", i), EXP_DATA[profile][i],
                        drp_data_seen[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // Drive one vector and compare the results
    task automatic run_test(input int n);
        string name;
        string kind;
        int    first_cycle;
        int    last_cycle;
        int    resp_after;
        int    errors_before;
        name          = vec_name[n];
        kind          = vec_kind[n];
        errors_before = errors;
        first_cycle   = cycle;
        last_cycle    = cycle;
        drp_count     = 0;
        if (kind == "temp")
        begin
            @(posedge clk);
            hbm_temperature <= vec_value[n][6:0];
        end
        if (kind == "mask")
            send_byte(hbm_ctrl_pkg::OP_PORT_MASK, first_cycle);
        for (int i = 0; i < vec_count[n]; i++)
        begin
            send_byte(vec_byte[n][i], last_cycle);
            if (i == 0 && kind != "mask")
                first_cycle = last_cycle;
        end
        if (kind == "clk")
        begin
            while (!(drp_count == WRITES && clk_locked === 1'b1))
                @(posedge clk);
        end
        repeat (4) @(posedge clk);

        resp_after = (kind == "clk") ? first_cycle : last_cycle;
        if (vec_resp[n] == NO_RESP)
            check_value(name, "response count", 0, resp_data_q.size());
        else
        begin
            check_value(name, "response count", 1, resp_data_q.size());
            if (resp_data_q.size() > 0)
            begin
                check_value(name, "response byte", vec_resp[n], 32'(resp_data_q[0]));
                check_value(name, "response cycle", resp_after + 2, resp_cycle_q[0]);
            end
        end

        if (kind == "idle")
        begin
            check_value(name, "start", 0, 32'(start));
            check_value(name, "read_write", 0, 32'(read_write));
            check_value(name, "address_inc", 0, 32'(address_inc));
            check_value(name, "port_mask", 0, port_mask);
            check_value(name, "length", 15, 32'(length));
        end
        else if (kind == "start")
            check_value(name, "start", vec_value[n], 32'(start));
        else if (kind == "rw")
            check_value(name, "read_write", vec_value[n], 32'(read_write));
        else if (kind == "ainc")
            check_value(name, "address_inc", vec_value[n], 32'(address_inc));
        else if (kind == "mask")
            check_value(name, "port_mask", vec_value[n], port_mask);
        else if (kind == "length")
            check_value(name, "length", vec_value[n], 32'(length));
        else if (kind == "clk")
        begin
            check_value(name, "first DRP request cycle", first_cycle + 2, drp_first_cycle);
            check_drp_writes(name, int'(vec_value[n]));
        end

        resp_data_q.delete();
        resp_cycle_q.delete();
        if (errors == errors_before)
            $display("Test %0s: ok", name);
        else
        begin
            $display("Test %0s: failed", name);
            failed_tests = failed_tests + 1;
        end
    endtask

    initial
    begin : main
        int          fd;
        int          fields;
        int          count;
        string       line;
        string       name;
        string       kind;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [7:0]  b3;
        logic [31:0] resp;
        logic [31:0] value;
        reset_state_machine = 1'b1;
        rx_valid            = 1'b0;
        rx_data             = 8'h00;
        hbm_temperature     = 7'h00;

        fd = $fopen("hbm_test_ctrl_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open vector file hbm_test_ctrl_vectors.txt");
            errors = errors + 1;
        end
        else
        begin
            while (!$feof(fd) && num_vectors < MAX_VECTORS)
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")  // Skip blanks and column notes
                begin
                    fields = $sscanf(line, "%s %s %d %h %h %h %h %h %h", name, kind, count,
                                     b0, b1, b2, b3, resp, value);
                    if (fields == 9)
                    begin
                        vec_name[num_vectors]  = name;
                        vec_kind[num_vectors]  = kind;
                        vec_count[num_vectors] = count;
                        vec_byte[num_vectors]  = '{b0, b1, b2, b3};
                        vec_resp[num_vectors]  = resp;
                        vec_value[num_vectors] = value;
                        num_vectors = num_vectors + 1;
                    end
                    else
                    begin
                        $display("Malformed vector line: %0s", line);
                        errors = errors + 1;
                    end
                end
            end
            $fclose(fd);
        end
        if (num_vectors == 0)
        begin
            $display("No test vectors were read");
            errors = errors + 1;
        end
        cycle_limit = num_vectors * 200;

        repeat (2) @(posedge clk);
        reset_state_machine <= 1'b0;

        for (int i = 0; i < num_vectors; i++)
            run_test(i);

        $display("Tests: %0d run, %0d failed, %0d check errors",
                 num_vectors, failed_tests, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
